//--- design/hsdom_bus_pkg.sv
package hsdom_bus_pkg;

    // byte address and data word of the master port
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // top address byte picks the target
    typedef logic [7:0] region_t;

    localparam region_t REGION_RAM = 8'h02;
    localparam region_t REGION_HSP = 8'h03;

    // request as seen on the master port
    typedef struct packed {
        addr_t addr;
        logic  we;
        strb_t be;
        data_t wdata;
    } bus_req_t;

    // response, valid with rvalid
    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    // target-side request, word index instead of byte address
    // targets only look at the low bits of idx
    typedef struct packed {
        addr_t idx;
        logic  we;
        strb_t be;
        data_t wdata;
    } mem_req_t;

endpackage

//--- design/hsdom_stream_pkg.sv
package hsdom_stream_pkg;

    // one sample on the stream ports
    typedef logic [31:0] sample_t;

    // register word offset inside the peripheral window
    typedef logic [1:0] reg_off_t;

    localparam reg_off_t REG_CTRL  = 2'd0;
    localparam reg_off_t REG_KEY   = 2'd1;
    localparam reg_off_t REG_COUNT = 2'd2;

    // settings from the register block to the datapath
    typedef struct packed {
        logic    enable;
        sample_t key;
    } hsp_ctrl_t;

endpackage

//--- design/hsdom_bus_port.sv
module hsdom_bus_port (
    input  logic                     hsdom_seq,
    input  logic                     rst_i,

    input  logic                     req_i,
    input  hsdom_bus_pkg::bus_req_t  breq_i,
    output logic                     gnt_o,

    output logic                     rvalid_o,
    input  logic                     rready_i,
    output hsdom_bus_pkg::bus_rsp_t  brsp_o,

    output logic                     mem_sel_o,
    output logic                     hsp_sel_o,
    output hsdom_bus_pkg::mem_req_t  tgt_req_o,
    input  hsdom_bus_pkg::data_t     mem_rdata_i,
    input  hsdom_bus_pkg::data_t     hsp_rdata_i
);

    import hsdom_bus_pkg::*;

    region_t region;
    logic    accept;

    logic rvalid_q;
    logic is_ram_q;
    logic is_hsp_q;
    logic is_wr_q;

    // only one request in flight but a new one may go in as the old response leaves
    assign gnt_o  = !rvalid_q || rready_i;
    assign accept = req_i && gnt_o;

    assign region    = breq_i.addr[31:24];
    assign mem_sel_o = accept && (region == REGION_RAM);
    assign hsp_sel_o = accept && (region == REGION_HSP);

    // word index from the byte address without the region byte
    assign tgt_req_o.idx   = addr_t'(breq_i.addr[23:2]);
    assign tgt_req_o.we    = breq_i.we;
    assign tgt_req_o.be    = breq_i.be;
    assign tgt_req_o.wdata = breq_i.wdata;

    always_ff @(posedge hsdom_seq) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (accept) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // decoded target kept for the response cycle
    always_ff @(posedge hsdom_seq) begin
        if (accept) begin
            is_ram_q <= mem_sel_o;
            is_hsp_q <= hsp_sel_o;
            is_wr_q  <= breq_i.we;
        end
    end

    // targets hold their read data until the next select,
    // so the response stays put under back-pressure
    always_comb begin
        brsp_o.err   = !is_ram_q && !is_hsp_q;
        brsp_o.rdata = '0;
        if (!is_wr_q) begin
            if (is_ram_q) begin
                brsp_o.rdata = mem_rdata_i;
            end else if (is_hsp_q) begin
                brsp_o.rdata = hsp_rdata_i;
            end
        end
    end

    assign rvalid_o = rvalid_q;

    a_rsp_hold: assert property (@(posedge hsdom_seq) disable iff (rst_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(brsp_o));

endmodule

//--- design/hsdom_mem.sv
module hsdom_mem #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                    hsdom_seq,
    input  logic                    sel_i,
    input  hsdom_bus_pkg::mem_req_t req_i,
    output hsdom_bus_pkg::data_t    rdata_o
);

    import hsdom_bus_pkg::*;

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    data_t            mem_q [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // addresses wrap around the depth
    assign idx = IDX_W'(req_i.idx % MEM_WORDS);

    always_ff @(posedge hsdom_seq) begin
        if (sel_i) begin
            if (req_i.we) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (req_i.be[b]) begin
                        mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                // read data stays until the next read
                rdata_o <= mem_q[idx];
            end
        end
    end

endmodule

//--- design/hsp_regs.sv
module hsp_regs (
    input  logic                         hsdom_seq,
    input  logic                         rst_i,

    input  logic                         sel_i,
    input  hsdom_bus_pkg::mem_req_t      req_i,
    output hsdom_bus_pkg::data_t         rdata_o,

    input  logic                         emitted_i,
    output hsdom_stream_pkg::hsp_ctrl_t  ctrl_o
);

    import hsdom_bus_pkg::*;
    import hsdom_stream_pkg::*;

    reg_off_t off;
    logic     wr_ctrl;
    logic     wr_key;
    logic     wr_count;

    logic    enable_q;
    sample_t key_q;
    data_t   count_q;

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t be);
        data_t res;
        res = old_val;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // only the low index bits select a register
    assign off      = reg_off_t'(req_i.idx);
    assign wr_ctrl  = sel_i && req_i.we && (off == REG_CTRL);
    assign wr_key   = sel_i && req_i.we && (off == REG_KEY);
    assign wr_count = sel_i && req_i.we && (off == REG_COUNT);

    always_ff @(posedge hsdom_seq) begin
        if (rst_i) begin
            enable_q <= 1'b0;
            key_q    <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ctrl && req_i.be[0]) begin
                enable_q <= req_i.wdata[0];
            end
            if (wr_key) begin
                key_q <= merge_bytes(key_q, req_i.wdata, req_i.be);
            end
            // clear beats a same-cycle increment
            if (wr_count) begin
                count_q <= '0;
            end else if (emitted_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge hsdom_seq) begin
        if (sel_i && !req_i.we) begin
            case (off)
                REG_CTRL:  rdata_o <= {31'b0, enable_q};
                REG_KEY:   rdata_o <= key_q;
                REG_COUNT: rdata_o <= count_q;
                default:   rdata_o <= '0;
            endcase
        end
    end

    assign ctrl_o.enable = enable_q;
    assign ctrl_o.key    = key_q;

endmodule

//--- design/hsp_stream.sv
module hsp_stream #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                         hsdom_seq,
    input  logic                         rst_i,

    input  hsdom_stream_pkg::hsp_ctrl_t  ctrl_i,

    input  hsdom_stream_pkg::sample_t    din_i,
    input  logic                         din_valid_i,
    output logic                         din_ready_o,

    output hsdom_stream_pkg::sample_t    dout_o,
    output logic                         dout_valid_o,
    input  logic                         dout_ready_i,

    output logic                         emitted_o
);

    import hsdom_stream_pkg::*;

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    sample_t          fifo_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] fill_q;

    logic full;
    logic empty;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (fill_q == CNT_W'(FIFO_DEPTH));
    assign empty = (fill_q == '0);

    // input stalls when disabled while output keeps draining
    assign din_ready_o  = ctrl_i.enable && !full;
    assign push         = din_valid_i && din_ready_o;
    assign dout_valid_o = !empty;
    assign pop          = dout_valid_o && dout_ready_i;

    always_ff @(posedge hsdom_seq) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop && !push) begin
                fill_q <= fill_q - 1'b1;
            end
        end
    end

    // key as it stands when the sample is taken
    always_ff @(posedge hsdom_seq) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= din_i ^ ctrl_i.key;
        end
    end

    assign dout_o    = fifo_q[rd_ptr_q];
    assign emitted_o = pop;

    // fill level stays in range and agrees with the pointer distance
    a_fill_ptrs: assert property (@(posedge hsdom_seq) disable iff (rst_i)
        (fill_q <= CNT_W'(FIFO_DEPTH)) && ((wr_ptr_q == rd_ptr_q) == (empty || full)));

    a_dout_hold: assert property (@(posedge hsdom_seq) disable iff (rst_i)
        dout_valid_o && !dout_ready_i |=> dout_valid_o && $stable(dout_o));

endmodule

//--- design/hsdom_top.sv
module hsdom_top #(
    parameter int unsigned MEM_WORDS  = 256,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                       hsdom_seq,
    input  logic                       rst_i,

    // master port
    input  logic                       req_i,
    input  hsdom_bus_pkg::bus_req_t    breq_i,
    output logic                       gnt_o,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    output hsdom_bus_pkg::bus_rsp_t    brsp_o,

    // sample stream
    input  hsdom_stream_pkg::sample_t  din_i,
    input  logic                       din_valid_i,
    output logic                       din_ready_o,
    output hsdom_stream_pkg::sample_t  dout_o,
    output logic                       dout_valid_o,
    input  logic                       dout_ready_i
);

    import hsdom_bus_pkg::*;
    import hsdom_stream_pkg::*;

    logic      mem_sel;
    logic      hsp_sel;
    mem_req_t  tgt_req;
    data_t     mem_rdata;
    data_t     hsp_rdata;
    hsp_ctrl_t hsp_ctrl;
    logic      hsp_emitted;

    hsdom_bus_port hsdom_bus_port_inst (
        .hsdom_seq   (hsdom_seq),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .breq_i      (breq_i),
        .gnt_o       (gnt_o),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .brsp_o      (brsp_o),
        .mem_sel_o   (mem_sel),
        .hsp_sel_o   (hsp_sel),
        .tgt_req_o   (tgt_req),
        .mem_rdata_i (mem_rdata),
        .hsp_rdata_i (hsp_rdata)
    );

    hsdom_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) hsdom_mem_inst (
        .hsdom_seq (hsdom_seq),
        .sel_i     (mem_sel),
        .req_i     (tgt_req),
        .rdata_o   (mem_rdata)
    );

    hsp_regs hsp_regs_inst (
        .hsdom_seq (hsdom_seq),
        .rst_i     (rst_i),
        .sel_i     (hsp_sel),
        .req_i     (tgt_req),
        .rdata_o   (hsp_rdata),
        .emitted_i (hsp_emitted),
        .ctrl_o    (hsp_ctrl)
    );

    hsp_stream #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) hsp_stream_inst (
        .hsdom_seq    (hsdom_seq),
        .rst_i        (rst_i),
        .ctrl_i       (hsp_ctrl),
        .din_i        (din_i),
        .din_valid_i  (din_valid_i),
        .din_ready_o  (din_ready_o),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i),
        .emitted_o    (hsp_emitted)
    );

endmodule

//--- bench/tb_checker.sv
module tb_checker #(
    parameter int unsigned MEM_WORDS  = 256,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                       hsdom_seq,
    input  logic                       rst_i,
    input  logic                       req_i,
    input  hsdom_bus_pkg::bus_req_t    breq_i,
    input  logic                       gnt_i,
    input  logic                       rvalid_i,
    input  logic                       rready_i,
    input  hsdom_bus_pkg::bus_rsp_t    brsp_i,
    input  hsdom_stream_pkg::sample_t  din_i,
    input  logic                       din_valid_i,
    input  logic                       din_ready_i,
    input  hsdom_stream_pkg::sample_t  dout_i,
    input  logic                       dout_valid_i,
    input  logic                       dout_ready_i,
    output int                         bus_errs_o,
    output int                         stream_errs_o,
    output int                         samples_left_o
);

    import hsdom_bus_pkg::*;
    import hsdom_stream_pkg::*;

    data_t    mem_model [int unsigned];
    logic     enable_m;
    sample_t  key_m;
    data_t    count_m;
    logic     count_clear;
    sample_t  exp_q [$];
    logic     rsp_pending;
    bus_rsp_t rsp_exp;
    int       bus_errs = 0;
    int       stream_errs = 0;
    int       samples_left = 0;

    assign bus_errs_o     = bus_errs;
    assign stream_errs_o  = stream_errs;
    assign samples_left_o = samples_left;

    function automatic data_t apply_strobes(data_t old_val, data_t new_val, strb_t be);
        data_t mask;
        for (int b = 0; b < $bits(strb_t); b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic compare_value(input string sig, input logic [63:0] exp_val,
                                 input logic [63:0] got_val, input logic on_bus);
        if (got_val !== exp_val) begin
            $display("Fail at time %0t: %s expected %h actual %h",
                     $time, sig, exp_val, got_val);
            if (on_bus) begin
                bus_errs++;
            end else begin
                stream_errs++;
            end
        end
    endtask

    // update the model and predict the response of an accepted request
    task automatic accept_request(input bus_req_t r);
        int unsigned widx;
        reg_off_t    off;
        widx    = 32'(r.addr[23:2]) % MEM_WORDS;
        off     = r.addr[3:2];
        rsp_exp = '0;
        if (r.addr[31:24] == REGION_RAM) begin
            if (r.we) begin
                mem_model[widx] = apply_strobes(mem_model[widx], r.wdata, r.be);
            end else begin
                rsp_exp.rdata = mem_model[widx];
            end
        end else if (r.addr[31:24] == REGION_HSP) begin
            if (r.we) begin
                if (off == REG_CTRL && r.be[0]) begin
                    enable_m = r.wdata[0];
                end else if (off == REG_KEY) begin
                    key_m = apply_strobes(key_m, r.wdata, r.be);
                end else if (off == REG_COUNT) begin
                    count_clear = 1'b1;
                end
            end else if (off == REG_CTRL) begin
                rsp_exp.rdata = {31'b0, enable_m};
            end else if (off == REG_KEY) begin
                rsp_exp.rdata = key_m;
            end else if (off == REG_COUNT) begin
                rsp_exp.rdata = count_m;
            end
        end else begin
            rsp_exp.err = 1'b1;
        end
        rsp_pending = 1'b1;
    endtask

    always @(posedge hsdom_seq) begin
        logic    push;
        logic    pop;
        sample_t head;
        if (rst_i) begin
            enable_m    = 1'b0;
            key_m       = '0;
            count_m     = '0;
            rsp_pending = 1'b0;
            exp_q.delete();
        end else begin
            // stream side sees the settings from before this edge
            compare_value("dout_valid_o", 64'(exp_q.size() != 0), 64'(dout_valid_i), 1'b0);
            compare_value("din_ready_o", 64'(enable_m && (exp_q.size() < FIFO_DEPTH)),
                          64'(din_ready_i), 1'b0);
            pop  = dout_valid_i && dout_ready_i;
            push = din_valid_i && din_ready_i;
            if (pop && exp_q.size() == 0) begin
                $display("Output handshake at time %0t with no sample expected", $time);
                stream_errs++;
            end else if (pop) begin
                head = exp_q.pop_front();
                compare_value("dout_o", 64'(head), 64'(dout_i), 1'b0);
            end
            if (push) begin
                exp_q.push_back(din_i ^ key_m);
            end

            // held response, taken when rready is high
            if (rsp_pending) begin
                compare_value("rvalid_o", 64'(1'b1), 64'(rvalid_i), 1'b1);
                compare_value("brsp_o", 64'(rsp_exp), 64'(brsp_i), 1'b1);
                compare_value("gnt_o", 64'(rready_i), 64'(gnt_i), 1'b1);
                rsp_pending = !rready_i;
            end else begin
                compare_value("rvalid_o", 64'(1'b0), 64'(rvalid_i), 1'b1);
                compare_value("gnt_o", 64'(1'b1), 64'(gnt_i), 1'b1);
            end
            count_clear = 1'b0;
            if (req_i && gnt_i) begin
                accept_request(breq_i);
            end

            // a clear beats an emit in the same cycle
            if (count_clear) begin
                count_m = '0;
            end else if (pop) begin
                count_m = count_m + 32'd1;
            end
        end
        samples_left = exp_q.size();
    end

endmodule

//--- bench/tb_top.sv
module tb_top;

    import hsdom_bus_pkg::*;
    import hsdom_stream_pkg::*;

    localparam int unsigned MEM_WORDS  = 256;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned SEED       = 32'hbdb5;
    localparam int          CLK_PERIOD = 4;
    localparam int          RAM_SPAN   = 16;
    localparam int          N_RAM_OPS  = 200;
    localparam int          N_BAD_OPS  = 24;
    localparam int          N_IDLE     = 12;
    localparam int          N_ROUNDS   = 6;
    localparam int          N_SAMPLES  = 24;
    localparam int          TOTAL_OPS  = RAM_SPAN + N_RAM_OPS + 2 * N_BAD_OPS + N_IDLE
                                         + N_ROUNDS * (N_SAMPLES + 7) + 6;

    logic      hsdom_seq;
    logic      rst_i;
    logic      req_i;
    bus_req_t  breq_i;
    logic      gnt_o;
    logic      rvalid_o;
    logic      rready_i = 1'b0;
    bus_rsp_t  brsp_o;
    sample_t   din_i;
    logic      din_valid_i;
    logic      din_ready_o;
    sample_t   dout_o;
    logic      dout_valid_o;
    logic      dout_ready_i = 1'b0;
    int        bus_errs;
    int        stream_errs;
    int        samples_left;

    hsdom_top #(
        .MEM_WORDS  (MEM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) hsdom_top_inst (
        .hsdom_seq    (hsdom_seq),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .breq_i       (breq_i),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .brsp_o       (brsp_o),
        .din_i        (din_i),
        .din_valid_i  (din_valid_i),
        .din_ready_o  (din_ready_o),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i)
    );

    tb_checker #(
        .MEM_WORDS  (MEM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) checker_inst (
        .hsdom_seq      (hsdom_seq),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .breq_i         (breq_i),
        .gnt_i          (gnt_o),
        .rvalid_i       (rvalid_o),
        .rready_i       (rready_i),
        .brsp_i         (brsp_o),
        .din_i          (din_i),
        .din_valid_i    (din_valid_i),
        .din_ready_i    (din_ready_o),
        .dout_i         (dout_o),
        .dout_valid_i   (dout_valid_o),
        .dout_ready_i   (dout_ready_i),
        .bus_errs_o     (bus_errs),
        .stream_errs_o  (stream_errs),
        .samples_left_o (samples_left)
    );

    initial begin
        hsdom_seq = 1'b0;
        forever #(CLK_PERIOD / 2) hsdom_seq = ~hsdom_seq;
    end

    // random back-pressure on both outputs
    always @(posedge hsdom_seq) begin
        rready_i     <= ($urandom_range(3) != 0);
        dout_ready_i <= ($urandom_range(1) != 0);
    end

    // RAM word with a random alias above the depth
    function automatic addr_t ram_addr(int w);
        logic [21:0] idx;
        idx = 22'(w + MEM_WORDS * $urandom_range(3));
        return {REGION_RAM, idx, 2'b00};
    endfunction

    function automatic addr_t bad_addr(int w);
        region_t region;
        do begin
            region = region_t'($urandom);
        end while (region == REGION_RAM || region == REGION_HSP);
        return {region, 22'(w), 2'b00};
    endfunction

    function automatic addr_t hsp_addr(reg_off_t off);
        return {REGION_HSP, 20'($urandom), off, 2'b00};
    endfunction

    // returns at the edge where the request is accepted
    task automatic bus_access(input addr_t addr, input logic we, input strb_t be,
                              input data_t wdata);
        req_i  <= 1'b1;
        breq_i <= '{addr: addr, we: we, be: be, wdata: wdata};
        @(posedge hsdom_seq);
        while (!gnt_o) begin
            @(posedge hsdom_seq);
        end
        req_i <= 1'b0;
    endtask

    task automatic send_samples(input int n);
        for (int i = 0; i < n; i++) begin
            din_i       <= $urandom;
            din_valid_i <= 1'b1;
            @(posedge hsdom_seq);
            while (!din_ready_o) begin
                @(posedge hsdom_seq);
            end
        end
        din_valid_i <= 1'b0;
    endtask

    // input idle and FIFO drained
    task automatic wait_stream_idle();
        din_valid_i <= 1'b0;
        @(posedge hsdom_seq);
        while (dout_valid_o) begin
            @(posedge hsdom_seq);
        end
    endtask

    initial begin
        int w;
        void'($urandom(SEED));
        rst_i       = 1'b1;
        req_i       = 1'b0;
        breq_i      = '0;
        din_i       = '0;
        din_valid_i = 1'b0;
        repeat (4) @(posedge hsdom_seq);
        rst_i <= 1'b0;

        // every word in use gets a full write first
        for (int i = 0; i < RAM_SPAN; i++) begin
            bus_access(ram_addr(i), 1'b1, 4'hf, $urandom);
        end
        for (int i = 0; i < N_RAM_OPS; i++) begin
            w = $urandom_range(RAM_SPAN - 1);
            if ($urandom_range(1) != 0) begin
                bus_access(ram_addr(w), 1'b1, strb_t'($urandom), $urandom);
            end else begin
                bus_access(ram_addr(w), 1'b0, 4'hf, '0);
            end
        end
        // unmapped access, then the RAM word with the same low bits
        for (int i = 0; i < N_BAD_OPS; i++) begin
            w = $urandom_range(RAM_SPAN - 1);
            bus_access(bad_addr(w), ($urandom_range(1) != 0), 4'hf, $urandom);
            bus_access(ram_addr(w), 1'b0, 4'hf, '0);
        end

        // stream still disabled after reset
        bus_access(hsp_addr(REG_CTRL), 1'b0, 4'hf, '0);
        din_i       <= $urandom;
        din_valid_i <= 1'b1;
        repeat (N_IDLE) @(posedge hsdom_seq);
        din_valid_i <= 1'b0;
        bus_access(hsp_addr(REG_COUNT), 1'b0, 4'hf, '0);

        for (int r = 0; r < N_ROUNDS; r++) begin
            wait_stream_idle();
            bus_access(hsp_addr(REG_KEY), 1'b1, strb_t'($urandom), $urandom);
            bus_access(hsp_addr(REG_CTRL), 1'b1, 4'hf, 32'h1);
            bus_access(hsp_addr(REG_CTRL), 1'b0, 4'hf, '0);
            bus_access(hsp_addr(REG_KEY), 1'b0, 4'hf, '0);
            send_samples(N_SAMPLES / 2);
            bus_access(hsp_addr(REG_COUNT), 1'b0, 4'hf, '0);
            send_samples(N_SAMPLES / 2);
            if (r == N_ROUNDS / 2) begin
                bus_access(hsp_addr(REG_COUNT), 1'b1, 4'hf, $urandom);
            end
            bus_access(hsp_addr(2'd3), 1'b0, 4'hf, '0);
            bus_access(hsp_addr(REG_COUNT), 1'b0, 4'hf, '0);
        end
        wait_stream_idle();
        bus_access(hsp_addr(REG_CTRL), 1'b1, 4'hf, 32'h0);
        bus_access(hsp_addr(REG_COUNT), 1'b0, 4'hf, '0);

        // let the last response leave
        @(posedge hsdom_seq);
        while (rvalid_o) begin
            @(posedge hsdom_seq);
        end
        @(negedge hsdom_seq);
        if (samples_left != 0) begin
            $display("%0d accepted samples were never emitted", samples_left);
        end
        $display("errors: bus %0d, stream %0d, samples left %0d",
                 bus_errs, stream_errs, samples_left);
        if (bus_errs == 0 && stream_errs == 0 && samples_left == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_OPS * 20 * CLK_PERIOD);
        $display("Timeout: run still busy after %0d cycles", TOTAL_OPS * 20);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog.f
design/hsdom_bus_pkg.sv
design/hsdom_stream_pkg.sv
design/hsdom_bus_port.sv
design/hsdom_mem.sv
design/hsp_regs.sv
design/hsp_stream.sv
design/hsdom_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top \
    -f verilog.f -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
